//--- common/ooo_pkg.sv
package ooo_pkg;

   parameter int ARF_WIDTH = 5;              // 32 architectural registers
   parameter int PRF_WIDTH = 6;              // 64 physical registers
   parameter int ROB_WIDTH = 4;              // slot index, robid adds a wrap bit
   parameter int ROB_NUM   = 1 << ROB_WIDTH;
   parameter int FREE_NUM  = 1 << PRF_WIDTH; // one free list entry per physical register

   typedef enum logic [1:0] {
      rob_idle     = 2'd0,
      rob_rollback = 2'd1,  // kill slots younger than the flush
      rob_walk     = 2'd2   // replay survivors into the speculative map
   } rob_state_t;

   typedef struct packed {
      logic                 valid;
      logic                 complete;
      logic                 is_wb;      // writes a destination register
      logic [ARF_WIDTH-1:0] arf_id;
      logic [PRF_WIDTH-1:0] T;
      logic [PRF_WIDTH-1:0] T_old;      // previous mapping, freed at retire
   } rob_entry_t;

endpackage

//--- rob/rob.sv
`timescale 1ns/1ns

module rob #(
   parameter int  ROB_NUM = ooo_pkg::ROB_NUM,
   localparam int ROB_W   = $clog2(ROB_NUM)
) (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           instr0_valid,
   input  logic                           instr1_valid,
   input  logic                           instr0_is_wb,
   input  logic                           instr1_is_wb,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr0_arf_id,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr1_arf_id,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr0_T,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr1_T,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr0_T_old,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr1_T_old,
   input  logic                           int0alu_wb_valid,
   input  logic                           int0mul_wb_valid,
   input  logic                           int1alu_wb_valid,
   input  logic                           int1lsu_wb_valid,
   input  logic [ROB_W:0]                 int0alu_wb_robid,
   input  logic [ROB_W:0]                 int0mul_wb_robid,
   input  logic [ROB_W:0]                 int1alu_wb_robid,
   input  logic [ROB_W:0]                 int1lsu_wb_robid,
   input  logic                           flush_valid,
   input  logic [ROB_W:0]                 flush_robid,
   output logic [1:0]                     rob_left,   // 0 full, 1 one left, 2 two or more
   output logic [ROB_W:0]                 instr0_robid,
   output logic [ROB_W:0]                 instr1_robid,
   output logic                           retire0_valid,
   output logic                           retire1_valid,
   output logic                           retire0_is_wb,
   output logic                           retire1_is_wb,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  retire0_arf_id,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  retire1_arf_id,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  retire0_T,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  retire1_T,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  retire0_T_old,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  retire1_T_old,
   output logic [ROB_W:0]                 retire0_robid,
   output logic [ROB_W:0]                 retire1_robid,
   output ooo_pkg::rob_state_t            rob_state,
   output logic                           walk0_valid,
   output logic                           walk1_valid,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  walk0_arf_id,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  walk1_arf_id,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  walk0_T,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  walk1_T
);

   ooo_pkg::rob_entry_t slot [ROB_NUM];
   ooo_pkg::rob_state_t state_nxt;

   logic [ROB_W:0]   head, tail, walk, flush_robid_q;   // wrap bit on top
   logic [ROB_W:0]   head_p1, tail_p1, walk_p1, walk_p2, used;
   logic [ROB_W-1:0] head_ptr, head_ptr1, tail_ptr, tail_ptr1, walk_ptr, walk_ptr1;
   logic [ROB_W-1:0] flush_dist;
   logic [1:0]       disp_num;
   logic             walk0_live, walk1_live, walk_done;
   logic [ROB_NUM-1:0] kill;
   logic [3:0]       wb_valid;
   logic [ROB_W:0]   wb_robid [4];

   assign head_p1   = head + 1'b1;
   assign tail_p1   = tail + 1'b1;
   assign walk_p1   = walk + 1'b1;
   assign walk_p2   = walk + 2'd2;
   assign head_ptr  = head[ROB_W-1:0];
   assign head_ptr1 = head_p1[ROB_W-1:0];
   assign tail_ptr  = tail[ROB_W-1:0];
   assign tail_ptr1 = tail_p1[ROB_W-1:0];
   assign walk_ptr  = walk[ROB_W-1:0];
   assign walk_ptr1 = walk_p1[ROB_W-1:0];

   assign wb_valid = {int1lsu_wb_valid, int1alu_wb_valid, int0mul_wb_valid, int0alu_wb_valid};
   assign wb_robid = '{int0alu_wb_robid, int0mul_wb_robid, int1alu_wb_robid, int1lsu_wb_robid};

   assign disp_num = instr0_valid + instr1_valid;
   assign used     = head - tail;
   assign rob_left = (used == ROB_NUM) ? 2'd0 : (used == ROB_NUM - 1) ? 2'd1 : 2'd2;

   // a lone instr1 takes the head slot
   assign instr0_robid = head;
   assign instr1_robid = instr0_valid ? head_p1 : head;

   // in-order retirement, held off during any flush or recovery
   assign retire0_valid = (rob_state == ooo_pkg::rob_idle) && !flush_valid &&
                          slot[tail_ptr].valid && slot[tail_ptr].complete;
   assign retire1_valid = retire0_valid && slot[tail_ptr1].valid && slot[tail_ptr1].complete;
   assign retire0_is_wb  = slot[tail_ptr].is_wb;
   assign retire1_is_wb  = slot[tail_ptr1].is_wb;
   assign retire0_arf_id = slot[tail_ptr].arf_id;
   assign retire1_arf_id = slot[tail_ptr1].arf_id;
   assign retire0_T      = slot[tail_ptr].T;
   assign retire1_T      = slot[tail_ptr1].T;
   assign retire0_T_old  = slot[tail_ptr].T_old;
   assign retire1_T_old  = slot[tail_ptr1].T_old;
   assign retire0_robid  = tail;
   assign retire1_robid  = tail_p1;

   // younger than the flush means further from tail
   assign flush_dist = flush_robid_q[ROB_W-1:0] - tail_ptr;

   always_comb begin
      for (int i = 0; i < ROB_NUM; i++)
         kill[i] = slot[i].valid && (ROB_W'(i) - tail_ptr > flush_dist);
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < ROB_NUM; i++) begin
            slot[i].valid    <= 1'b0;
            slot[i].complete <= 1'b0;
         end
      end else begin
         if (instr0_valid)
            slot[head_ptr] <= '{valid: 1'b1, complete: 1'b0, is_wb: instr0_is_wb,
                                arf_id: instr0_arf_id, T: instr0_T, T_old: instr0_T_old};
         if (instr1_valid)
            slot[instr0_valid ? head_ptr1 : head_ptr] <= '{valid: 1'b1, complete: 1'b0,
               is_wb: instr1_is_wb, arf_id: instr1_arf_id, T: instr1_T, T_old: instr1_T_old};
         for (int k = 0; k < 4; k++)
            if (wb_valid[k])
               slot[wb_robid[k][ROB_W-1:0]].complete <= 1'b1;
         if (retire0_valid)
            slot[tail_ptr].valid <= 1'b0;
         if (retire1_valid)
            slot[tail_ptr1].valid <= 1'b0;
         if (rob_state == ooo_pkg::rob_rollback)
            for (int i = 0; i < ROB_NUM; i++)
               if (kill[i])
                  slot[i].valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         head <= '0;
         tail <= '0;
         walk <= '0;
      end else begin
         tail <= tail + retire0_valid + retire1_valid;
         if (rob_state == ooo_pkg::rob_rollback) begin
            head <= flush_robid_q + 1'b1;
            walk <= tail;     // walk restarts from the oldest survivor
         end else begin
            head <= head + disp_num;
            walk <= walk_p2;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (flush_valid)
         flush_robid_q <= flush_robid;
   end

   // walk two slots per cycle up to head
   assign walk0_live  = (walk != head);
   assign walk1_live  = walk0_live && (walk_p1 != head);
   assign walk_done   = !walk1_live || (walk_p2 == head);
   assign walk0_valid = (rob_state == ooo_pkg::rob_walk) && walk0_live && slot[walk_ptr].is_wb;
   assign walk1_valid = (rob_state == ooo_pkg::rob_walk) && walk1_live && slot[walk_ptr1].is_wb;
   assign walk0_arf_id = slot[walk_ptr].arf_id;
   assign walk1_arf_id = slot[walk_ptr1].arf_id;
   assign walk0_T      = slot[walk_ptr].T;
   assign walk1_T      = slot[walk_ptr1].T;

   always_comb begin
      state_nxt = rob_state;
      case (rob_state)
         ooo_pkg::rob_idle:     if (flush_valid) state_nxt = ooo_pkg::rob_rollback;
         ooo_pkg::rob_rollback: if (!flush_valid) state_nxt = ooo_pkg::rob_walk;
         ooo_pkg::rob_walk: begin
            if (flush_valid)
               state_nxt = ooo_pkg::rob_rollback;   // a newer flush restarts recovery
            else if (walk_done)
               state_nxt = ooo_pkg::rob_idle;
         end
         default:               state_nxt = ooo_pkg::rob_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n)
         rob_state <= ooo_pkg::rob_idle;
      else
         rob_state <= state_nxt;
   end

   a_disp_idle: assert property (@(posedge clk) disable iff (!reset_n)
      (instr0_valid || instr1_valid) |-> rob_state == ooo_pkg::rob_idle);

   a_disp_room: assert property (@(posedge clk) disable iff (!reset_n)
      disp_num <= rob_left);

   for (genvar k = 0; k < 4; k++) begin : g_wb_chk
      a_wb_live: assert property (@(posedge clk) disable iff (!reset_n)
         wb_valid[k] |-> slot[wb_robid[k][ROB_W-1:0]].valid);
   end

endmodule

//--- rename/rename_map.sv
`timescale 1ns/1ns

module rename_map (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           instr0_valid,
   input  logic                           instr1_valid,
   input  logic                           instr0_is_wb,
   input  logic                           instr1_is_wb,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr0_arf_id,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr1_arf_id,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr0_T,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  instr1_T,
   input  logic                           retire0_valid,
   input  logic                           retire1_valid,
   input  logic                           retire0_is_wb,
   input  logic                           retire1_is_wb,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  retire0_arf_id,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  retire1_arf_id,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  retire0_T,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  retire1_T,
   input  ooo_pkg::rob_state_t            rob_state,
   input  logic                           walk0_valid,
   input  logic                           walk1_valid,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  walk0_arf_id,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  walk1_arf_id,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  walk0_T,
   input  logic [ooo_pkg::PRF_WIDTH-1:0]  walk1_T,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  instr0_T_old,
   output logic [ooo_pkg::PRF_WIDTH-1:0]  instr1_T_old
);

   localparam int ARF_NUM = 1 << ooo_pkg::ARF_WIDTH;

   logic [ooo_pkg::PRF_WIDTH-1:0] spec_map [ARF_NUM];
   logic [ooo_pkg::PRF_WIDTH-1:0] arch_map [ARF_NUM];

   assign instr0_T_old = spec_map[instr0_arf_id];
   // same destination in one pair, instr1 replaces what instr0 just mapped
   assign instr1_T_old = (instr0_valid && instr0_is_wb && instr0_arf_id == instr1_arf_id) ?
                         instr0_T : spec_map[instr1_arf_id];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < ARF_NUM; i++)
            spec_map[i] <= i[ooo_pkg::PRF_WIDTH-1:0];   // identity
      end else begin
         case (rob_state)
            ooo_pkg::rob_rollback: spec_map <= arch_map;
            ooo_pkg::rob_walk: begin
               if (walk0_valid)
                  spec_map[walk0_arf_id] <= walk0_T;
               if (walk1_valid)
                  spec_map[walk1_arf_id] <= walk1_T;   // younger wins
            end
            default: begin
               if (instr0_valid && instr0_is_wb)
                  spec_map[instr0_arf_id] <= instr0_T;
               if (instr1_valid && instr1_is_wb)
                  spec_map[instr1_arf_id] <= instr1_T;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < ARF_NUM; i++)
            arch_map[i] <= i[ooo_pkg::PRF_WIDTH-1:0];
      end else begin
         if (retire0_valid && retire0_is_wb)
            arch_map[retire0_arf_id] <= retire0_T;
         if (retire1_valid && retire1_is_wb)
            arch_map[retire1_arf_id] <= retire1_T;
      end
   end

endmodule

//--- rename/free_list.sv
`timescale 1ns/1ns

module free_list #(
   parameter int  PRF_WIDTH = ooo_pkg::PRF_WIDTH,
   localparam int DEPTH     = 1 << PRF_WIDTH
) (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic [1:0]           alloc_num,
   input  logic                 release0_valid,
   input  logic                 release1_valid,
   input  logic [PRF_WIDTH-1:0] release0_T,
   input  logic [PRF_WIDTH-1:0] release1_T,
   input  ooo_pkg::rob_state_t  rob_state,
   input  logic [1:0]           walk_num,
   output logic [PRF_WIDTH-1:0] alloc0_T,
   output logic [PRF_WIDTH-1:0] alloc1_T
);

   localparam int ARF_NUM = 1 << ooo_pkg::ARF_WIDTH;

   logic [PRF_WIDTH-1:0] fl [DEPTH];
   logic [PRF_WIDTH:0]   alloc_ptr, commit_ptr, release_ptr;   // wrap bit on top
   logic [PRF_WIDTH:0]   alloc_p1, release_p1, occupancy;
   logic [1:0]           release_num;

   assign alloc_p1    = alloc_ptr + 1'b1;
   assign release_p1  = release_ptr + 1'b1;
   assign release_num = release0_valid + release1_valid;
   assign occupancy   = release_ptr - alloc_ptr;

   assign alloc0_T = fl[alloc_ptr[PRF_WIDTH-1:0]];
   assign alloc1_T = fl[alloc_p1[PRF_WIDTH-1:0]];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < DEPTH; i++)
            fl[i] <= PRF_WIDTH'(i + ARF_NUM);   // live part holds ARF_NUM and up
      end else begin
         if (release0_valid)
            fl[release_ptr[PRF_WIDTH-1:0]] <= release0_T;
         if (release1_valid)
            fl[release0_valid ? release_p1[PRF_WIDTH-1:0] : release_ptr[PRF_WIDTH-1:0]]
               <= release1_T;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         alloc_ptr   <= '0;
         commit_ptr  <= '0;
         release_ptr <= (PRF_WIDTH + 1)'(DEPTH - ARF_NUM);
      end else begin
         release_ptr <= release_ptr + release_num;
         commit_ptr  <= commit_ptr + release_num;   // one per retired destination
         case (rob_state)
            ooo_pkg::rob_rollback: alloc_ptr <= commit_ptr;
            ooo_pkg::rob_walk:     alloc_ptr <= alloc_ptr + walk_num;
            default:               alloc_ptr <= alloc_ptr + alloc_num;
         endcase
      end
   end

   // sized so a pair can always be renamed
   a_never_dry: assert property (@(posedge clk) disable iff (!reset_n)
      occupancy >= 2);

endmodule

//--- design/ooo_backend.sv
`timescale 1ns/1ns

module ooo_backend #(
   parameter int  ROB_NUM   = ooo_pkg::ROB_NUM,
   parameter int  PRF_WIDTH = ooo_pkg::PRF_WIDTH,
   localparam int ROB_W     = $clog2(ROB_NUM)
) (
   input  logic                           clk,
   input  logic                           reset_n,
   input  logic                           instr0_valid,
   input  logic                           instr1_valid,
   input  logic                           instr0_is_wb,
   input  logic                           instr1_is_wb,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr0_arf_id,
   input  logic [ooo_pkg::ARF_WIDTH-1:0]  instr1_arf_id,
   input  logic                           int0alu_wb_valid,
   input  logic                           int0mul_wb_valid,
   input  logic                           int1alu_wb_valid,
   input  logic                           int1lsu_wb_valid,
   input  logic [ROB_W:0]                 int0alu_wb_robid,
   input  logic [ROB_W:0]                 int0mul_wb_robid,
   input  logic [ROB_W:0]                 int1alu_wb_robid,
   input  logic [ROB_W:0]                 int1lsu_wb_robid,
   input  logic                           flush_valid,
   input  logic [ROB_W:0]                 flush_robid,
   output logic [1:0]                     rob_left,
   output ooo_pkg::rob_state_t            rob_state,
   output logic [ROB_W:0]                 instr0_robid,
   output logic [ROB_W:0]                 instr1_robid,
   output logic                           retire0_valid,
   output logic                           retire1_valid,
   output logic                           retire0_is_wb,
   output logic                           retire1_is_wb,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  retire0_arf_id,
   output logic [ooo_pkg::ARF_WIDTH-1:0]  retire1_arf_id,
   output logic [PRF_WIDTH-1:0]           retire0_T,
   output logic [PRF_WIDTH-1:0]           retire1_T,
   output logic [PRF_WIDTH-1:0]           retire0_T_old,
   output logic [PRF_WIDTH-1:0]           retire1_T_old,
   output logic [ROB_W:0]                 retire0_robid,
   output logic [ROB_W:0]                 retire1_robid
);

   logic [PRF_WIDTH-1:0]          alloc0_T, alloc1_T, instr0_T, instr1_T;
   logic [PRF_WIDTH-1:0]          instr0_T_old, instr1_T_old, walk0_T, walk1_T;
   logic [ooo_pkg::ARF_WIDTH-1:0] walk0_arf_id, walk1_arf_id;
   logic                          walk0_valid, walk1_valid;
   logic [1:0]                    alloc_num, walk_num;

   // first renamed destination takes alloc0
   assign instr0_T  = alloc0_T;
   assign instr1_T  = (instr0_valid && instr0_is_wb) ? alloc1_T : alloc0_T;
   assign alloc_num = (instr0_valid && instr0_is_wb) + (instr1_valid && instr1_is_wb);
   assign walk_num  = walk0_valid + walk1_valid;

   rob #(.ROB_NUM(ROB_NUM)) u_rob (.*);

   rename_map u_rename_map (.*);

   free_list #(.PRF_WIDTH(PRF_WIDTH)) u_free_list (
      .clk            (clk),
      .reset_n        (reset_n),
      .alloc_num      (alloc_num),
      .release0_valid (retire0_valid && retire0_is_wb),
      .release1_valid (retire1_valid && retire1_is_wb),
      .release0_T     (retire0_T_old),
      .release1_T     (retire1_T_old),
      .rob_state      (rob_state),
      .walk_num       (walk_num),
      .alloc0_T       (alloc0_T),
      .alloc1_T       (alloc1_T)
   );

endmodule

//--- dv/ooo_backend_tb.sv
`timescale 1ns/1ns

module ooo_backend_tb;

   localparam int ROB_NUM = ooo_pkg::ROB_NUM;
   localparam int ROB_W   = ooo_pkg::ROB_WIDTH;
   localparam int PRF_W   = ooo_pkg::PRF_WIDTH;
   localparam int ARF_W   = ooo_pkg::ARF_WIDTH;
   localparam int ARF_NUM = 1 << ARF_W;
   localparam int NUM_OPS = 1500;
   // one op is a cycle, a flush with its recovery stays far below 40 cycles
   localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

   typedef struct packed {
      logic [ROB_W:0]   robid;
      logic             is_wb;
      logic [ARF_W-1:0] arf_id;
      logic [PRF_W-1:0] t;
      logic [PRF_W-1:0] t_old;
      logic             done;
   } model_entry_t;

   logic clk, reset_n;
   logic instr0_valid, instr1_valid, instr0_is_wb, instr1_is_wb;
   logic [ARF_W-1:0] instr0_arf_id, instr1_arf_id;
   logic int0alu_wb_valid, int0mul_wb_valid, int1alu_wb_valid, int1lsu_wb_valid;
   logic [ROB_W:0] int0alu_wb_robid, int0mul_wb_robid, int1alu_wb_robid, int1lsu_wb_robid;
   logic flush_valid;
   logic [ROB_W:0] flush_robid;
   logic [1:0] rob_left;
   ooo_pkg::rob_state_t rob_state;
   logic [ROB_W:0] instr0_robid, instr1_robid, retire0_robid, retire1_robid;
   logic retire0_valid, retire1_valid, retire0_is_wb, retire1_is_wb;
   logic [ARF_W-1:0] retire0_arf_id, retire1_arf_id;
   logic [PRF_W-1:0] retire0_T, retire1_T, retire0_T_old, retire1_T_old;

   integer seed;
   int cycles;
   bit seen_rollback, seen_walk;
   logic [ROB_W:0] next_robid;          // robid the next dispatch must get
   logic [PRF_W-1:0] spec_map [ARF_NUM];
   logic [PRF_W-1:0] arch_map [ARF_NUM];
   logic [PRF_W-1:0] free_q [$];        // free registers in allocation order
   model_entry_t inflight [$];          // oldest first

   ooo_backend #(.ROB_NUM(ROB_NUM), .PRF_WIDTH(PRF_W)) dut0 (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   end

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s expected %0d actual %0d", name, expected, actual);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   endtask

   function automatic int pick(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic int expected_left(input int used);
      if (used == ROB_NUM)
         return 0;
      else if (used == ROB_NUM - 1)
         return 1;
      return 2;
   endfunction

   task automatic check_retire(input string port, input logic [ROB_W:0] robid,
                               input logic is_wb, input logic [ARF_W-1:0] arf_id,
                               input logic [PRF_W-1:0] t, input logic [PRF_W-1:0] t_old);
      model_entry_t e;
      e = inflight.pop_front();
      compare({port, "_robid"}, e.robid, robid);
      compare({port, "_is_wb"}, e.is_wb, is_wb);
      compare({port, "_arf_id"}, e.arf_id, arf_id);
      compare({port, "_T"}, e.t, t);
      compare({port, "_T_old"}, e.t_old, t_old);
      if (e.is_wb) begin
         arch_map[e.arf_id] = e.t;
         free_q.push_back(e.t_old);     // previous mapping goes back to the free list
      end
   endtask

   task automatic rename_instr(input string name, input logic [ROB_W:0] robid,
                               input logic is_wb, input logic [ARF_W-1:0] arf_id);
      model_entry_t e;
      compare({name, "_robid"}, next_robid, robid);
      e.robid  = next_robid;
      e.is_wb  = is_wb;
      e.arf_id = arf_id;
      e.t      = free_q[0];
      e.t_old  = spec_map[arf_id];
      e.done   = 1'b0;
      inflight.push_back(e);
      if (is_wb) begin
         void'(free_q.pop_front());
         spec_map[arf_id] = e.t;        // a second instr of the pair sees this one
      end
      next_robid = next_robid + 1'b1;
   endtask

   // at a negedge, check outputs and replay what the next edge does
   task automatic observe_cycle();
      logic exp0, exp1;
      logic [3:0] wv;
      logic [ROB_W:0] wid [4];
      compare("rob_state", ooo_pkg::rob_idle, rob_state);
      compare("rob_left", expected_left(inflight.size()), rob_left);
      exp0 = inflight.size() > 0 && inflight[0].done;
      exp1 = exp0 && inflight.size() > 1 && inflight[1].done;
      compare("retire0_valid", exp0, retire0_valid);
      compare("retire1_valid", exp1, retire1_valid);
      if (exp0)
         check_retire("retire0", retire0_robid, retire0_is_wb, retire0_arf_id,
                      retire0_T, retire0_T_old);
      if (exp1)
         check_retire("retire1", retire1_robid, retire1_is_wb, retire1_arf_id,
                      retire1_T, retire1_T_old);
      wv  = {int1lsu_wb_valid, int1alu_wb_valid, int0mul_wb_valid, int0alu_wb_valid};
      wid = '{int0alu_wb_robid, int0mul_wb_robid, int1alu_wb_robid, int1lsu_wb_robid};
      for (int k = 0; k < 4; k++)
         if (wv[k])
            foreach (inflight[i])
               if (inflight[i].robid == wid[k])
                  inflight[i].done = 1'b1;
      if (instr0_valid)
         rename_instr("instr0", instr0_robid, instr0_is_wb, instr0_arf_id);
      if (instr1_valid)
         rename_instr("instr1", instr1_robid, instr1_is_wb, instr1_arf_id);
   endtask

   task automatic drive_next(input bit draining);
      int n, idx;
      logic v0, v1;
      logic [ARF_W-1:0] a0, a1;
      logic [3:0] wv;
      logic [ROB_W:0] wid [4];
      n = draining ? 0 : pick(3);
      if (n > ROB_NUM - inflight.size())
         n = ROB_NUM - inflight.size();
      v0 = (n == 2) || (n == 1 && pick(2) == 0);
      v1 = (n == 2) || (n == 1 && !v0);   // a lone instr1 now and then
      a0 = pick(ARF_NUM);
      a1 = (pick(4) == 0) ? a0 : pick(ARF_NUM);
      for (int k = 0; k < 4; k++) begin
         wv[k]  = 1'b0;
         wid[k] = '0;
         if (inflight.size() > 0 && pick(2) == 0) begin
            idx    = pick(inflight.size());
            wv[k]  = !inflight[idx].done;
            wid[k] = inflight[idx].robid;
         end
      end
      @(posedge clk);
      instr0_valid     <= v0;
      instr1_valid     <= v1;
      instr0_is_wb     <= pick(4) != 0;
      instr1_is_wb     <= pick(4) != 0;
      instr0_arf_id    <= a0;
      instr1_arf_id    <= a1;
      int0alu_wb_valid <= wv[0];
      int0mul_wb_valid <= wv[1];
      int1alu_wb_valid <= wv[2];
      int1lsu_wb_valid <= wv[3];
      int0alu_wb_robid <= wid[0];
      int0mul_wb_robid <= wid[1];
      int1alu_wb_robid <= wid[2];
      int1lsu_wb_robid <= wid[3];
   endtask

   task automatic watch_recovery();
      compare("retire0_valid in recovery", 0, retire0_valid);
      compare("retire1_valid in recovery", 0, retire1_valid);
      if (rob_state == ooo_pkg::rob_rollback)
         seen_rollback = 1'b1;
      if (rob_state == ooo_pkg::rob_walk)
         seen_walk = 1'b1;
   endtask

   task automatic run_flush();
      int idx, hold;
      logic [ROB_W:0] frobid;
      model_entry_t e;
      idx    = pick(inflight.size());
      frobid = inflight[idx].robid;
      hold   = 1 + pick(3);
      seen_rollback = 1'b0;
      seen_walk     = 1'b0;
      @(posedge clk);
      instr0_valid     <= 1'b0;
      instr1_valid     <= 1'b0;
      int0alu_wb_valid <= 1'b0;
      int0mul_wb_valid <= 1'b0;
      int1alu_wb_valid <= 1'b0;
      int1lsu_wb_valid <= 1'b0;
      flush_valid      <= 1'b1;
      flush_robid      <= frobid;
      repeat (hold) begin
         @(negedge clk);
         watch_recovery();
         @(posedge clk);
      end
      flush_valid <= 1'b0;
      @(negedge clk);
      while (rob_state != ooo_pkg::rob_idle) begin   // the timeout bounds this
         watch_recovery();
         @(negedge clk);
      end
      compare("flush reached rollback", 1, seen_rollback);
      compare("flush reached walk", 1, seen_walk);
      // younger ones give their registers back in original order
      while (inflight.size() > idx + 1) begin
         e = inflight.pop_back();
         if (e.is_wb)
            free_q.push_front(e.t);
      end
      spec_map = arch_map;
      foreach (inflight[i])
         if (inflight[i].is_wb)
            spec_map[inflight[i].arf_id] = inflight[i].t;
      next_robid = frobid + 1'b1;
   endtask

   initial begin
      int op;
      seed             = 32'h8fc7;
      cycles           = 0;
      clk              = 1'b0;
      reset_n          = 1'b0;
      instr0_valid     = 1'b0;
      instr1_valid     = 1'b0;
      instr0_is_wb     = 1'b0;
      instr1_is_wb     = 1'b0;
      instr0_arf_id    = '0;
      instr1_arf_id    = '0;
      int0alu_wb_valid = 1'b0;
      int0mul_wb_valid = 1'b0;
      int1alu_wb_valid = 1'b0;
      int1lsu_wb_valid = 1'b0;
      int0alu_wb_robid = '0;
      int0mul_wb_robid = '0;
      int1alu_wb_robid = '0;
      int1lsu_wb_robid = '0;
      flush_valid      = 1'b0;
      flush_robid      = '0;
      next_robid       = '0;
      for (int i = 0; i < ARF_NUM; i++) begin
         spec_map[i] = PRF_W'(i);       // identity map out of reset
         arch_map[i] = PRF_W'(i);
      end
      for (int i = ARF_NUM; i < (1 << PRF_W); i++)
         free_q.push_back(PRF_W'(i));
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      compare("reset rob_left", 2, rob_left);
      compare("reset rob_state", ooo_pkg::rob_idle, rob_state);
      compare("reset retire0_valid", 0, retire0_valid);
      compare("reset retire1_valid", 0, retire1_valid);
      op = 0;
      while (op < NUM_OPS || inflight.size() > 0) begin   // then drain what is left
         observe_cycle();
         if (op < NUM_OPS && inflight.size() > 0 && pick(16) == 0) begin
            run_flush();
         end else begin
            drive_next(op >= NUM_OPS);
            @(negedge clk);
         end
         op++;
      end
      observe_cycle();
      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- verilog.f
common/ooo_pkg.sv
rob/rob.sv
rename/rename_map.sv
rename/free_list.sv
design/ooo_backend.sv
dv/ooo_backend_tb.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - files:
      - common/ooo_pkg.sv
      - rob/rob.sv
      - rename/rename_map.sv
      - rename/free_list.sv
      - design/ooo_backend.sv
  - target: test
    files:
      - dv/ooo_backend_tb.sv
